// ==== mutative_types.sv ====
package mutative_types;

    // fixed geometry, the PLRU decode assumes exactly 8 ways
    localparam int WAYS         = 8;
    localparam int WAY_IDX_BITS = $clog2(WAYS);
    localparam int SET_BITS     = 4;
    localparam int SET_SIZE     = 2 ** SET_BITS;
    localparam int TAG_BITS     = 10;
    localparam int ADDR_BITS    = 16;
    localparam int OFFSET_BITS  = ADDR_BITS - TAG_BITS - SET_BITS;

    typedef logic [WAY_IDX_BITS-1:0] way_idx_t;
    typedef logic [WAYS-1:0]         way_mask_t; // one-hot or group mask
    typedef logic [SET_BITS-1:0]     set_idx_t;
    typedef logic [TAG_BITS-1:0]     tag_t;
    typedef logic [1:0]              setup_t;    // 0 dm, 1 2-way, 2 4-way, 3 8-way

    typedef struct packed {
        tag_t                   tag;
        set_idx_t               set_index;
        logic [OFFSET_BITS-1:0] offset;
    } cache_address_t;

    typedef struct packed {
        cache_address_t addr;
    } cpu_req_t;

    typedef struct packed {
        logic           hit;
        way_idx_t       way; // physical way
        cache_address_t addr;
    } cpu_resp_t;

    typedef struct packed {
        tag_t     tag;
        set_idx_t set_index;
    } mem_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_mem_wait,
        st_fill,
        st_respond
    } ctrl_state_t;

endpackage

// ==== mutative_plru.sv ====
module mutative_plru (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           hit,
    input  mutative_types::way_idx_t       hit_way,    // virtual way inside the group
    input  mutative_types::cache_address_t cache_address,
    input  mutative_types::setup_t         setup,
    output mutative_types::way_idx_t       evict_way
);

    typedef logic [mutative_types::WAYS-2:0] tree_t;

    // bit 0 root, bits 1..2 second level, bits 3..6 leaves (8-way layout)
    tree_t plru_bits [mutative_types::SET_SIZE];

    tree_t                    cur_bits;
    tree_t                    next_bits;
    mutative_types::way_idx_t virt_way;

    logic top_half;
    logic mid_node;
    logic mid_half;
    logic leaf_node;

    assign cur_bits = plru_bits[cache_address.set_index];

    // node bit records the half used last
    always_comb begin
        next_bits = cur_bits;
        unique case (setup)
            2'd1: begin
                next_bits[0] = hit_way[0];
            end
            2'd2: begin
                next_bits[0] = hit_way[1];
                if (hit_way[1]) begin
                    next_bits[2] = hit_way[0];
                end else begin
                    next_bits[1] = hit_way[0];
                end
            end
            2'd3: begin
                next_bits[0] = hit_way[2];
                if (hit_way[2]) begin
                    next_bits[2] = hit_way[1];
                end else begin
                    next_bits[1] = hit_way[1];
                end
                case (hit_way[2:1])
                    2'd0: next_bits[3] = hit_way[0];
                    2'd1: next_bits[4] = hit_way[0];
                    2'd2: next_bits[5] = hit_way[0];
                    2'd3: next_bits[6] = hit_way[0];
                endcase
            end
            default: begin
                next_bits = cur_bits; // dm has no tree
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < mutative_types::SET_SIZE; s++) begin
                plru_bits[s] <= '0;
            end
        end else if (hit) begin
            plru_bits[cache_address.set_index] <= next_bits;
        end
    end

    // 8-way walk, victim goes away from the recently used half
    assign top_half = ~cur_bits[0];
    assign mid_node = top_half ? cur_bits[2] : cur_bits[1];
    assign mid_half = ~mid_node;

    always_comb begin
        case ({top_half, mid_half})
            2'd0:    leaf_node = cur_bits[3];
            2'd1:    leaf_node = cur_bits[4];
            2'd2:    leaf_node = cur_bits[5];
            default: leaf_node = cur_bits[6];
        endcase
    end

    always_comb begin
        unique case (setup)
            2'd1: begin
                virt_way = {2'b00, ~cur_bits[0]};
            end
            2'd2: begin
                // 4-way uses root plus bits 1 and 2 as leaves
                virt_way = {1'b0, ~cur_bits[0], cur_bits[0] ? ~cur_bits[1] : ~cur_bits[2]};
            end
            2'd3: begin
                virt_way = {top_half, mid_half, ~leaf_node};
            end
            default: begin
                virt_way = '0;
            end
        endcase
    end

    // place virtual victim inside the group picked by the tag
    always_comb begin
        unique case (setup)
            2'd0: begin
                evict_way = cache_address.tag[2:0];
            end
            2'd1: begin
                evict_way = {cache_address.tag[1:0], virt_way[0]};
            end
            2'd2: begin
                evict_way = {cache_address.tag[0], virt_way[1:0]};
            end
            default: begin
                evict_way = virt_way;
            end
        endcase
    end

endmodule

// ==== mutative_tag_store.sv ====
module mutative_tag_store (
    input  logic                           clk,
    input  logic                           rst,
    input  mutative_types::setup_t         setup,
    input  mutative_types::cache_address_t lookup_addr,
    output logic                           lookup_hit,
    output mutative_types::way_idx_t       lookup_way,
    input  logic                           fill_en,
    input  mutative_types::way_idx_t       fill_way,
    input  mutative_types::tag_t           fill_tag
);

    mutative_types::way_mask_t valid_bits [mutative_types::SET_SIZE];
    mutative_types::tag_t      tag_mem [mutative_types::SET_SIZE][mutative_types::WAYS];

    mutative_types::way_mask_t group_mask;
    mutative_types::way_mask_t match;

    // ways that may hold this address in the current mode
    always_comb begin
        unique case (setup)
            2'd0: begin
                group_mask = mutative_types::way_mask_t'(1'b1) << lookup_addr.tag[2:0];
            end
            2'd1: begin
                group_mask = mutative_types::way_mask_t'(2'b11)
                             << {lookup_addr.tag[1:0], 1'b0};
            end
            2'd2: begin
                group_mask = mutative_types::way_mask_t'(4'hf)
                             << {lookup_addr.tag[0], 2'b00};
            end
            default: begin
                group_mask = '1;
            end
        endcase
    end

    always_comb begin
        for (int w = 0; w < mutative_types::WAYS; w++) begin
            match[w] = group_mask[w]
                       && valid_bits[lookup_addr.set_index][w]
                       && (tag_mem[lookup_addr.set_index][w] == lookup_addr.tag);
        end
    end

    // at most one way matches
    always_comb begin
        lookup_hit = 1'b0;
        lookup_way = '0;
        for (int w = 0; w < mutative_types::WAYS; w++) begin
            if (match[w]) begin
                lookup_hit = 1'b1;
                lookup_way = mutative_types::way_idx_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < mutative_types::SET_SIZE; s++) begin
                valid_bits[s] <= '0;
            end
        end else if (fill_en) begin
            valid_bits[lookup_addr.set_index][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[lookup_addr.set_index][fill_way] <= fill_tag;
        end
    end

endmodule

// ==== mutative_controller.sv ====
module mutative_controller #(
    parameter int REQ_DEPTH   = 2,
    parameter int MEM_CREDITS = 1
) (
    input  logic                           clk,
    input  logic                           rst,
    input  mutative_types::setup_t         setup,
    input  logic                           req_valid,
    input  mutative_types::cpu_req_t       req,
    output logic                           req_credit,
    output logic                           resp_valid,
    output mutative_types::cpu_resp_t      resp,
    output logic                           mem_req_valid,
    output mutative_types::mem_req_t       mem_req,
    input  logic                           mem_credit,
    input  logic                           mem_fill,
    output mutative_types::cache_address_t lookup_addr,
    input  logic                           lookup_hit,
    input  mutative_types::way_idx_t       lookup_way,
    input  mutative_types::way_idx_t       evict_way,
    output logic                           fill_en,
    output mutative_types::way_idx_t       fill_way,
    output logic                           access_en,
    output mutative_types::way_idx_t       access_way
);

    localparam int PTR_BITS  = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_BITS  = $clog2(REQ_DEPTH + 1);
    localparam int CRED_BITS = $clog2(MEM_CREDITS + 1);

    mutative_types::cpu_req_t    queue [REQ_DEPTH];
    logic [PTR_BITS-1:0]         wr_ptr;
    logic [PTR_BITS-1:0]         rd_ptr;
    logic [CNT_BITS-1:0]         req_count;   // queue occupancy
    logic [CRED_BITS-1:0]        mem_credits;
    mutative_types::ctrl_state_t state;
    mutative_types::cpu_req_t    cur_req;
    logic                        hit_q;
    mutative_types::way_idx_t    way_q;       // hit way or victim
    logic                        mem_sent;
    logic                        pop;
    mutative_types::way_idx_t    phys_way;

    function automatic logic [PTR_BITS-1:0] advance(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // physical way modulo the group size
    function automatic mutative_types::way_idx_t virtual_way(
        input mutative_types::setup_t   mode,
        input mutative_types::way_idx_t way
    );
        case (mode)
            2'd0:    return '0;
            2'd1:    return {2'b00, way[0]};
            2'd2:    return {1'b0, way[1:0]};
            default: return way;
        endcase
    endfunction

    assign pop        = (state == mutative_types::st_idle) && (req_count != '0);
    assign req_credit = pop; // one credit back per dequeued entry

    always_ff @(posedge clk) begin
        if (req_valid) begin
            queue[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            req_count <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= advance(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= advance(rd_ptr);
            end
            req_count <= req_count + CNT_BITS'(req_valid) - CNT_BITS'(pop);
        end
    end

    assign mem_req_valid = (state == mutative_types::st_mem_wait) && !mem_sent
                           && (mem_credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_credits <= CRED_BITS'(MEM_CREDITS);
        end else begin
            mem_credits <= mem_credits + CRED_BITS'(mem_credit) - CRED_BITS'(mem_req_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= mutative_types::st_idle;
            mem_sent <= 1'b0;
        end else begin
            unique case (state)
                mutative_types::st_idle: begin
                    if (pop) begin
                        state <= mutative_types::st_lookup;
                    end
                end
                mutative_types::st_lookup: begin
                    mem_sent <= 1'b0;
                    state    <= lookup_hit ? mutative_types::st_respond
                                           : mutative_types::st_mem_wait;
                end
                mutative_types::st_mem_wait: begin
                    if (mem_req_valid) begin
                        mem_sent <= 1'b1;
                    end
                    if (mem_fill && mem_sent) begin
                        state <= mutative_types::st_fill;
                    end
                end
                mutative_types::st_fill: begin
                    state <= mutative_types::st_respond;
                end
                default: begin
                    state <= mutative_types::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_req <= queue[rd_ptr];
        end
        if (state == mutative_types::st_lookup) begin
            hit_q <= lookup_hit;
            way_q <= lookup_hit ? lookup_way : evict_way;
        end
    end

    assign lookup_addr = cur_req.addr;
    assign mem_req     = '{tag: cur_req.addr.tag, set_index: cur_req.addr.set_index};

    assign fill_en    = (state == mutative_types::st_fill);
    assign fill_way   = way_q;
    assign access_en  = ((state == mutative_types::st_lookup) && lookup_hit) || fill_en;
    assign phys_way   = fill_en ? way_q : lookup_way;
    assign access_way = virtual_way(setup, phys_way);

    assign resp_valid = (state == mutative_types::st_respond);
    assign resp       = '{hit: hit_q, way: way_q, addr: cur_req.addr};

endmodule

// ==== mutative_cache.sv ====
module mutative_cache #(
    parameter int REQ_DEPTH   = 2,
    parameter int MEM_CREDITS = 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  mutative_types::setup_t    setup,
    input  logic                      req_valid,
    input  mutative_types::cpu_req_t  req,
    output logic                      req_credit,
    output logic                      resp_valid,
    output mutative_types::cpu_resp_t resp,
    output logic                      mem_req_valid,
    output mutative_types::mem_req_t  mem_req,
    input  logic                      mem_credit,
    input  logic                      mem_fill
);

    mutative_types::cache_address_t lookup_addr;
    logic                           lookup_hit;
    mutative_types::way_idx_t       lookup_way;
    mutative_types::way_idx_t       evict_way;
    logic                           fill_en;
    mutative_types::way_idx_t       fill_way;
    logic                           access_en;
    mutative_types::way_idx_t       access_way;

    mutative_controller #(
        .REQ_DEPTH   (REQ_DEPTH),
        .MEM_CREDITS (MEM_CREDITS)
    ) ctrl0 (
        .clk           (clk),
        .rst           (rst),
        .setup         (setup),
        .req_valid     (req_valid),
        .req           (req),
        .req_credit    (req_credit),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_credit    (mem_credit),
        .mem_fill      (mem_fill),
        .lookup_addr   (lookup_addr),
        .lookup_hit    (lookup_hit),
        .lookup_way    (lookup_way),
        .evict_way     (evict_way),
        .fill_en       (fill_en),
        .fill_way      (fill_way),
        .access_en     (access_en),
        .access_way    (access_way)
    );

    mutative_tag_store tags0 (
        .clk         (clk),
        .rst         (rst),
        .setup       (setup),
        .lookup_addr (lookup_addr),
        .lookup_hit  (lookup_hit),
        .lookup_way  (lookup_way),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_tag    (lookup_addr.tag) // address held through the fill
    );

    mutative_plru plru0 (
        .clk           (clk),
        .rst           (rst),
        .hit           (access_en),
        .hit_way       (access_way),
        .cache_address (lookup_addr),
        .setup         (setup),
        .evict_way     (evict_way)
    );

endmodule

// ==== mutative_cache_assert.sv ====
module mutative_cache_assert #(
    parameter int REQ_DEPTH   = 2,
    parameter int MEM_CREDITS = 1
) (
    input logic                                 clk,
    input logic                                 rst,
    input mutative_types::setup_t               setup,
    input logic                                 mem_req_valid,
    input logic                                 mem_credit,
    input logic [$clog2(MEM_CREDITS+1)-1:0]     mem_credits,
    input logic [$clog2(REQ_DEPTH+1)-1:0]       req_count
);
    timeunit 1ns;
    timeprecision 1ps;

    int credits_held; // wide count of memory credits on hand

    always_ff @(posedge clk) begin
        if (rst) begin
            credits_held <= MEM_CREDITS;
        end else begin
            credits_held <= credits_held + int'(mem_credit) - int'(mem_req_valid);
        end
    end

    credit_range: assert property (@(posedge clk) disable iff (rst)
        (credits_held >= 0) && (credits_held <= MEM_CREDITS)
        && (int'(mem_credits) == credits_held) && (req_count <= REQ_DEPTH))
        else $error("credit or queue counter out of range");

    mem_req_needs_credit: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> (credits_held > 0))
        else $error("memory request issued without a credit");

    setup_stable: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $stable(setup))
        else $error("setup changed outside reset");

endmodule

bind mutative_controller mutative_cache_assert #(
    .REQ_DEPTH   (REQ_DEPTH),
    .MEM_CREDITS (MEM_CREDITS)
) chk0 (
    .clk           (clk),
    .rst           (rst),
    .setup         (setup),
    .mem_req_valid (mem_req_valid),
    .mem_credit    (mem_credit),
    .mem_credits   (mem_credits),
    .req_count     (req_count)
);

// ==== tb_mutative_cache.sv ====
module tb_mutative_cache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int REQ_DEPTH   = 2;
    localparam int MEM_CREDITS = 1;
    localparam int MAX_CYCLES  = 4000; // six short tests, a few hundred cycles each

    logic                          clk = 1'b0;
    logic                          rst;
    mutative_types::setup_t        setup;
    logic                          req_valid;
    mutative_types::cpu_req_t      req;
    logic                          req_credit;
    logic                          resp_valid;
    mutative_types::cpu_resp_t     resp;
    logic                          mem_req_valid;
    mutative_types::mem_req_t      mem_req;
    logic                          mem_credit;
    logic                          mem_fill;

    mutative_types::cpu_resp_t exp_resp[$];
    mutative_types::mem_req_t  exp_mem[$];
    mutative_types::mem_req_t  mem_pend[$];
    mutative_types::mem_req_t  exp_mem_head;

    logic                 ref_valid [16][8];
    mutative_types::tag_t ref_tag [16][8];
    logic [6:0]           ref_tree [16];

    int resp_errs = 0;
    int mem_errs = 0;
    int other_errs = 0;
    int cycles = 0;
    int req_credits;
    int dut_mem_credits;
    int accepted;
    int credit_pulses;
    int sent;
    int got;
    int hits_seen;
    int mem_reqs_seen;
    logic mem_hold = 1'b0;
    logic [31:0] rng = 32'hc781;

    mutative_cache #(.REQ_DEPTH(REQ_DEPTH), .MEM_CREDITS(MEM_CREDITS)) dut0 (
        .clk(clk), .rst(rst), .setup(setup), .req_valid(req_valid), .req(req),
        .req_credit(req_credit), .resp_valid(resp_valid), .resp(resp),
        .mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_credit(mem_credit),
        .mem_fill(mem_fill)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // physical way of virtual way v in the group the tag selects
    function automatic mutative_types::way_idx_t group_way(input mutative_types::setup_t m,
            input mutative_types::tag_t t, input mutative_types::way_idx_t v);
        case (m)
            2'd0:    return t[2:0];
            2'd1:    return {t[1:0], v[0]};
            2'd2:    return {t[0], v[1:0]};
            default: return v;
        endcase
    endfunction

    function automatic mutative_types::way_idx_t tree_victim(input logic [6:0] b,
            input mutative_types::setup_t m);
        logic top;
        logic half;
        logic leaf;
        top  = ~b[0];
        half = top ? ~b[2] : ~b[1];
        leaf = b[3 + {top, half}];
        case (m)
            2'd1:    return {2'b00, ~b[0]};
            2'd2:    return {1'b0, top, half};
            2'd3:    return {top, half, ~leaf};
            default: return '0;
        endcase
    endfunction

    // each node remembers the half that was used last
    function automatic logic [6:0] tree_touch(input logic [6:0] b,
            input mutative_types::setup_t m, input mutative_types::way_idx_t v);
        logic [6:0] n;
        n = b;
        if (m == 2'd1) begin
            n[0] = v[0];
        end else if (m == 2'd2) begin
            n[0] = v[1];
            n[v[1] ? 2 : 1] = v[0];
        end else if (m == 2'd3) begin
            n[0] = v[2];
            n[v[2] ? 2 : 1] = v[1];
            n[3 + v[2:1]] = v[0];
        end
        return n;
    endfunction

    // reference directory: returns the expected response and updates state
    function automatic mutative_types::cpu_resp_t model_access(
            input mutative_types::cache_address_t a);
        mutative_types::cpu_resp_t r;
        mutative_types::way_idx_t  v;
        mutative_types::way_idx_t  p;
        int gsize;
        gsize = 1 << setup;
        r = '{hit: 1'b0, way: '0, addr: a};
        for (int i = 0; i < gsize; i++) begin
            p = group_way(setup, a.tag, 3'(i));
            if (ref_valid[a.set_index][p] && ref_tag[a.set_index][p] == a.tag) begin
                r.hit = 1'b1;
                r.way = p;
                v = 3'(i);
            end
        end
        if (!r.hit) begin
            v = tree_victim(ref_tree[a.set_index], setup);
            r.way = group_way(setup, a.tag, v);
            ref_valid[a.set_index][r.way] = 1'b1;
            ref_tag[a.set_index][r.way] = a.tag;
        end
        ref_tree[a.set_index] = tree_touch(ref_tree[a.set_index], setup, v);
        return r;
    endfunction

    // sampling before the edge updates, all outputs come from registers
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d responses seen", cycles, got, sent);
            $display("Checks failed");
            $finish;
        end
        if (!rst) begin
            if (req_valid) accepted++;
            if (req_credit) credit_pulses++;
            if (credit_pulses > accepted) begin
                $display("req_credit pulsed with no request queued");
                other_errs++;
            end
            if (mem_credit) dut_mem_credits++;
            if (mem_req_valid) begin
                mem_reqs_seen++;
                if (dut_mem_credits == 0) begin
                    $display("memory request issued without a credit");
                    mem_errs++;
                end
                dut_mem_credits--;
                mem_pend.push_back(mem_req);
                if (exp_mem.size() == 0) begin
                    $display("unexpected memory request");
                    mem_errs++;
                end else begin
                    exp_mem_head = exp_mem.pop_front();
                    if (mem_req != exp_mem_head) begin
                        $display("FAIL mem_req got %h exp %h", mem_req, exp_mem_head);
                        mem_errs++;
                    end
                end
            end
            if (resp_valid) begin
                got++;
                if (resp.hit) hits_seen++;
                if (setup == 2'd0 && resp.way != resp.addr.tag[2:0]) begin
                    $display("FAIL resp.way %h tag %h", resp.way, resp.addr.tag);
                    resp_errs++;
                end
                if (exp_resp.size() == 0) begin
                    $display("response without a request");
                    resp_errs++;
                end else if (resp != exp_resp[0]) begin
                    $display("FAIL resp got %h exp %h", resp, exp_resp[0]);
                    resp_errs++;
                    void'(exp_resp.pop_front());
                end else begin
                    void'(exp_resp.pop_front());
                end
            end
        end
    end

    // memory model, serves requests in order with random delays
    initial begin
        int d;
        forever begin
            @(negedge clk);
            if (mem_pend.size() > 0 && !mem_hold) begin
                d = int'(next_rand() % 4);
                repeat (d) @(negedge clk);
                mem_credit = 1'b1;
                @(negedge clk);
                mem_credit = 1'b0;
                d = int'(next_rand() % 5);
                repeat (d) @(negedge clk);
                mem_fill = 1'b1;
                @(negedge clk);
                mem_fill = 1'b0;
                void'(mem_pend.pop_front());
            end
        end
    end

    task automatic reset_mode(input mutative_types::setup_t m);
        rst = 1'b1;
        setup = m;
        repeat (8) @(negedge clk);
        for (int s = 0; s < 16; s++) begin
            ref_tree[s] = '0;
            for (int w = 0; w < 8; w++) ref_valid[s][w] = 1'b0;
        end
        req_credits = REQ_DEPTH;
        dut_mem_credits = MEM_CREDITS;
        accepted = 0;
        credit_pulses = 0;
        rst = 1'b0;
        @(negedge clk);
    endtask

    task automatic send_req(input mutative_types::tag_t t, input mutative_types::set_idx_t s);
        mutative_types::cache_address_t a;
        mutative_types::cpu_resp_t      r;
        a = '{tag: t, set_index: s, offset: 2'(next_rand())};
        while (req_credits == 0) begin
            req_valid = 1'b0;
            @(negedge clk);
        end
        r = model_access(a);
        exp_resp.push_back(r);
        if (!r.hit) exp_mem.push_back(mutative_types::mem_req_t'{tag: t, set_index: s});
        sent++;
        req_credits--;
        req_valid = 1'b1;
        req = '{addr: a};
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_done();
        while (got != sent || mem_pend.size() != 0) @(negedge clk);
    endtask

    // requester side credit return, seen on the falling edge
    always @(negedge clk) if (!rst && req_credit) req_credits++;

    task automatic first_access_8way();
        int m0;
        reset_mode(2'd3);
        m0 = mem_reqs_seen;
        send_req(10'h123, 4'h5);
        wait_done();
        if (mem_reqs_seen - m0 != 1) begin
            $display("first miss issued %0d memory requests", mem_reqs_seen - m0);
            other_errs++;
        end
        send_req(10'h123, 4'h5);
        wait_done();
    endtask

    task automatic plru_4way();
        reset_mode(2'd2);
        for (int i = 1; i <= 4; i++) send_req(10'(2 * i), 4'h3);
        send_req(10'h6, 4'h3);
        send_req(10'h2, 4'h3);
        send_req(10'h8, 4'h3);
        for (int i = 5; i <= 8; i++) send_req(10'(2 * i), 4'h3);
        send_req(10'h3, 4'h3); // odd tag goes to the other half
        wait_done();
    endtask

    task automatic direct_mapped();
        int h0;
        reset_mode(2'd0);
        send_req(10'h011, 4'h7);
        send_req(10'h012, 4'h7);
        send_req(10'h021, 4'h7);
        send_req(10'h011, 4'h7);
        wait_done();
        h0 = hits_seen;
        send_req(10'h012, 4'h7);
        wait_done();
        if (hits_seen - h0 != 1) begin
            $display("tag with other low bits was evicted");
            other_errs++;
        end
    endtask

    task automatic two_way();
        reset_mode(2'd1);
        send_req(10'h005, 4'h1);
        send_req(10'h009, 4'h1);
        send_req(10'h00d, 4'h1);
        send_req(10'h006, 4'h1);
        send_req(10'h009, 4'h1);
        send_req(10'h011, 4'h1);
        send_req(10'h00d, 4'h1);
        wait_done();
    endtask

    task automatic credit_backpressure();
        int m0;
        int c0;
        reset_mode(2'd3);
        mem_hold = 1'b1;
        m0 = mem_reqs_seen;
        fork
            for (int i = 0; i < 5; i++) send_req(10'(16 + i), 4'h9);
            begin
                repeat (40) @(negedge clk);
                if (mem_reqs_seen - m0 != MEM_CREDITS || accepted != REQ_DEPTH + 1) begin
                    $display("held memory: %0d mem requests, %0d accepted",
                             mem_reqs_seen - m0, accepted);
                    other_errs++;
                end
                mem_hold = 1'b0;
            end
        join
        wait_done();
        c0 = credit_pulses;
        if (c0 != 5) begin
            $display("req_credit pulsed %0d times for 5 requests", c0);
            other_errs++;
        end
    endtask

    task automatic reset_clears();
        int h0;
        reset_mode(2'd3);
        h0 = hits_seen;
        send_req(10'h123, 4'h5);
        send_req(10'h012, 4'h7);
        send_req(10'h005, 4'h1);
        wait_done();
        if (hits_seen != h0) begin
            $display("hit after reset between modes");
            other_errs++;
        end
    endtask

    initial begin
        rst = 1'b1;
        setup = 2'd3;
        req_valid = 1'b0;
        req = '0;
        mem_credit = 1'b0;
        mem_fill = 1'b0;
        sent = 0;
        got = 0;
        hits_seen = 0;
        mem_reqs_seen = 0;
        @(negedge clk);
        first_access_8way();
        plru_4way();
        direct_mapped();
        two_way();
        credit_backpressure();
        reset_clears();
        $display("errors: resp %0d, mem %0d, other %0d", resp_errs, mem_errs, other_errs);
        if (resp_errs + mem_errs + other_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
mutative_types.sv
mutative_plru.sv
mutative_tag_store.sv
mutative_controller.sv
mutative_cache.sv
mutative_cache_assert.sv
tb_mutative_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mutative_cache
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module mutative_cache \
		mutative_types.sv mutative_plru.sv mutative_tag_store.sv \
		mutative_controller.sv mutative_cache.sv

clean:
	rm -rf $(OBJ_DIR)
